/* sim.f */
rtl/vdp_glue_pkg.sv
rtl/host_req_if.sv
rtl/host_port_capture.sv
rtl/raster_aligner.sv
rtl/scanline_expander.sv
rtl/vdp_glue_top.sv
testbench/tb_clock_gen.sv
testbench/tb_vdp_glue.sv

/* Bender.yml */
package:
  name: vdp_glue

sources:
  # design, package first
  - files:
      - rtl/vdp_glue_pkg.sv
      - rtl/host_req_if.sv
      - rtl/host_port_capture.sv
      - rtl/raster_aligner.sv
      - rtl/scanline_expander.sv
      - rtl/vdp_glue_top.sv

  # testbench
  - target: simulation
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_vdp_glue.sv

/* testbench/tb_vdp_glue.sv */
// directed tests of vdp_glue_top; inputs change 1 ns after posedge, outputs sampled there too
`timescale 1ns/1ns

module tb_vdp_glue;

    // wrap test ~39k cycles, the rest ~4k, rounded up generously
    localparam int TIMEOUT_CYCLES = 120_000;
    localparam int REQ_WAIT_LIMIT = 8;

    logic                        clk_w;
    logic                        reset_n_w;
    vdp_glue_pkg::host_addr_t    mode;
    logic                        csr_n;
    logic                        csw_n;
    vdp_glue_pkg::host_data_t    cdo;
    vdp_glue_pkg::host_data_t    cdi;
    logic                        vdp_req;
    logic                        vdp_wrt;
    vdp_glue_pkg::host_addr_t    vdp_adr;
    vdp_glue_pkg::host_data_t    vdp_dbo;
    vdp_glue_pkg::host_data_t    vdp_dbi;
    vdp_glue_pkg::colour6_t      vdp_r;
    vdp_glue_pkg::colour6_t      vdp_g;
    vdp_glue_pkg::colour6_t      vdp_b;
    logic                        scanlin_n;
    logic                        pal_mode;
    logic                        vdp_hdmi_reset;
    vdp_glue_pkg::vdp_coord_t    vdp_cx;
    vdp_glue_pkg::vdp_coord_t    vdp_cy;
    vdp_glue_pkg::colour8_t      rgb_r;
    vdp_glue_pkg::colour8_t      rgb_g;
    vdp_glue_pkg::colour8_t      rgb_b;
    vdp_glue_pkg::raster_coord_t cx;
    vdp_glue_pkg::raster_coord_t cy;
    logic                        video_reset;

    integer seed = 28;
    int     cycles = 0;
    int     host_errors = 0;
    int     colour_errors = 0;
    int     coord_errors = 0;
    int     flag_errors = 0;
    int     other_errors = 0;

    tb_clock_gen tb_clock_gen_inst (.clk_w(clk_w), .reset_n_w(reset_n_w));

    vdp_glue_top vdp_glue_top_inst (.*);

    // ------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------

    task automatic check_data(input string name, input vdp_glue_pkg::host_data_t got,
                              input vdp_glue_pkg::host_data_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            host_errors++;
        end
    endtask

    // request outputs while req is expected high
    task automatic check_host(input vdp_glue_pkg::host_addr_t exp_adr,
                              input vdp_glue_pkg::host_data_t exp_dbo, input logic exp_wrt);
        if (vdp_wrt !== exp_wrt) begin
            $display("[FAIL] vdp_wrt: got 0x%0h expected 0x%0h", vdp_wrt, exp_wrt);
            host_errors++;
        end
        if (vdp_adr !== exp_adr) begin
            $display("[FAIL] vdp_adr: got 0x%0h expected 0x%0h", vdp_adr, exp_adr);
            host_errors++;
        end
        check_data("vdp_dbo", vdp_dbo, exp_dbo);
    endtask

    task automatic check_colour(input string name, input vdp_glue_pkg::colour8_t got,
                                input vdp_glue_pkg::colour8_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            colour_errors++;
        end
    endtask

    task automatic check_coord(input string name, input vdp_glue_pkg::raster_coord_t got,
                               input vdp_glue_pkg::raster_coord_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            coord_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
            flag_errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // stimulus and sampling point
    task automatic next_cycle();
        @(posedge clk_w);
        #1;
    endtask

    task automatic wait_request(output logic found);
        int n;
        found = 1'b0;
        for (n = 0; n < REQ_WAIT_LIMIT && !found; n++) begin
            next_cycle();
            found = vdp_req;
        end
    endtask

    task automatic count_requests(input int n_cycles, output int count);
        count = 0;
        repeat (n_cycles) begin
            next_cycle();
            if (vdp_req) count++;
        end
    endtask

    // hdmi reset pulse, raster ends up parked on the ntsc start
    task automatic park_raster();
        pal_mode       = 1'b0;
        vdp_hdmi_reset = 1'b1;
        next_cycle();
        vdp_hdmi_reset = 1'b0;
        check_flag("video_reset", video_reset, 1'b1);
        next_cycle();
        check_flag("video_reset", video_reset, 1'b0);
        check_coord("cx", cx, vdp_glue_pkg::START_X);
        check_coord("cy", cy, vdp_glue_pkg::NTSC_START_Y);
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------

    // one strobe edge, one request; level and release give none
    task automatic test_host_access(input logic is_write, input vdp_glue_pkg::host_addr_t adr,
                                    input vdp_glue_pkg::host_data_t dat);
        logic found;
        int   count;
        mode = adr;
        cdo  = dat;
        if (is_write) csw_n = 1'b0;
        else csr_n = 1'b0;
        wait_request(found);
        if (!found) begin
            $display("no request seen after the strobe fell");
            other_errors++;
        end else begin
            check_host(adr, dat, is_write);
        end
        count_requests(REQ_WAIT_LIMIT, count);
        if (count != 0) begin
            $display("extra request while the strobe was held low");
            other_errors++;
        end
        csw_n = 1'b1;
        csr_n = 1'b1;
        // both high in sample gives no request
        count_requests(REQ_WAIT_LIMIT, count);
        if (count != 0) begin
            $display("request seen after the strobe was released");
            other_errors++;
        end
    endtask

    task automatic test_read_data();
        vdp_glue_pkg::host_data_t dbi;
        dbi     = vdp_glue_pkg::host_data_t'($random(seed));
        vdp_dbi = dbi;
        next_cycle();
        check_data("cdi", cdi, dbi);
    endtask

    // random colours, checked one cycle after they were driven
    task automatic test_colour(input logic scan_n, input int n_cycles);
        vdp_glue_pkg::colour6_t r;
        vdp_glue_pkg::colour6_t g;
        vdp_glue_pkg::colour6_t b;
        logic                   dim;
        int                     i;
        scanlin_n = scan_n;
        for (i = 0; i <= n_cycles; i++) begin
            if (i > 0) begin
                next_cycle();
                check_colour("rgb_r", rgb_r, dim ? {1'b0, r, 1'b0} : {r, 2'b00});
                check_colour("rgb_g", rgb_g, dim ? {1'b0, g, 1'b0} : {g, 2'b00});
                check_colour("rgb_b", rgb_b, dim ? {1'b0, b, 1'b0} : {b, 2'b00});
            end
            r = vdp_glue_pkg::colour6_t'($random(seed));
            g = vdp_glue_pkg::colour6_t'($random(seed));
            b = vdp_glue_pkg::colour6_t'($random(seed));
            // cy here is the line the edge will see
            dim   = !scan_n && cy[0];
            vdp_r = r;
            vdp_g = g;
            vdp_b = b;
        end
    endtask

    task automatic test_misaligned(input logic pal, input int n_after);
        int h_tot;
        int v_tot;
        int sy;
        int lin;
        h_tot    = pal ? vdp_glue_pkg::PAL_H_TOTAL : vdp_glue_pkg::NTSC_H_TOTAL;
        v_tot    = pal ? vdp_glue_pkg::PAL_V_TOTAL : vdp_glue_pkg::NTSC_V_TOTAL;
        sy       = pal ? vdp_glue_pkg::PAL_START_Y : vdp_glue_pkg::NTSC_START_Y;
        pal_mode = pal;
        // move off the start position if sitting on it
        if (cx == vdp_glue_pkg::START_X && cy == sy) next_cycle();
        vdp_cx = '0;
        vdp_cy = '0;
        next_cycle();
        vdp_cx = 11'd1;
        vdp_cy = 11'd1;
        check_flag("video_reset", video_reset, 1'b1);
        next_cycle();
        check_flag("video_reset", video_reset, 1'b0);
        check_coord("cx", cx, vdp_glue_pkg::START_X);
        check_coord("cy", cy, sy);
        repeat (n_after) next_cycle();
        // linear pixel index within the frame
        lin = (sy * h_tot + vdp_glue_pkg::START_X + n_after) % (h_tot * v_tot);
        check_coord("cx", cx, lin % h_tot);
        check_coord("cy", cy, lin / h_tot);
    endtask

    task automatic test_aligned();
        park_raster();
        vdp_cx = '0;
        vdp_cy = '0;
        next_cycle();
        vdp_cx = 11'd1;
        vdp_cy = 11'd1;
        check_flag("video_reset", video_reset, 1'b0);
        next_cycle();
        check_flag("video_reset", video_reset, 1'b0);
    endtask

    // 45 lines from the ntsc start reach the frame wrap
    task automatic test_wrap();
        park_raster();
        repeat (45 * vdp_glue_pkg::NTSC_H_TOTAL) next_cycle();
        check_coord("cx", cx, 0);
        check_coord("cy", cy, 0);
    endtask

    // ------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_w);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        int total;
        mode           = '0;
        csr_n          = 1'b1;
        csw_n          = 1'b1;
        cdo            = '0;
        vdp_dbi        = '0;
        vdp_r          = '0;
        vdp_g          = '0;
        vdp_b          = '0;
        scanlin_n      = 1'b1;
        pal_mode       = 1'b0;
        vdp_hdmi_reset = 1'b0;
        // keep the vdp away from its origin
        vdp_cx         = 11'd1;
        vdp_cy         = 11'd1;
        wait (reset_n_w === 1'b1);
        // reset values still held right after release
        check_flag("vdp_req", vdp_req, 1'b0);
        check_flag("vdp_wrt", vdp_wrt, 1'b0);
        check_flag("video_reset", video_reset, 1'b0);
        check_colour("rgb_r", rgb_r, '0);
        check_coord("cx", cx, vdp_glue_pkg::START_X);
        check_coord("cy", cy, vdp_glue_pkg::NTSC_START_Y);
        next_cycle();
        test_host_access(1'b1, 2'h2, 8'ha5);
        test_host_access(1'b0, 2'h1, 8'h3c);
        test_read_data();
        test_colour(1'b1, 32);
        // two full lines so both parities are covered
        test_colour(1'b0, 2 * vdp_glue_pkg::NTSC_H_TOTAL + 8);
        test_misaligned(1'b0, 1000);
        test_misaligned(1'b1, 1000);
        test_aligned();
        test_wrap();
        total = host_errors + colour_errors + coord_errors + flag_errors + other_errors;
        $display("errors: host %0d, colour %0d, coord %0d, flag %0d, other %0d, total %0d",
                 host_errors, colour_errors, coord_errors, flag_errors, other_errors, total);
        if (total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
// 4 ns clk_w from time zero; reset_n_w low for the first three rising edges, released 1 ns after
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_w,
    output logic reset_n_w
);

    // half of the 4 ns period
    initial begin
        clk_w = 1'b0;
        forever #2 clk_w = ~clk_w;
    end

    // release off the edge, same offset as the stimulus
    initial begin
        reset_n_w = 1'b0;
        repeat (3) @(posedge clk_w);
        #1;
        reset_n_w = 1'b1;
    end

endmodule

/* rtl/vdp_glue_top.sv */
// glue around an external v9958 core; vdp_* video inputs assumed on clk_w, one pixel per cycle
`timescale 1ns/1ns

module vdp_glue_top (
    input  logic                        clk_w,
    input  logic                        reset_n_w,

    // host port
    input  vdp_glue_pkg::host_addr_t    mode,
    input  logic                        csr_n,
    input  logic                        csw_n,
    input  vdp_glue_pkg::host_data_t    cdo,
    output vdp_glue_pkg::host_data_t    cdi,

    // request side of the vdp core
    output logic                        vdp_req,
    output logic                        vdp_wrt,
    output vdp_glue_pkg::host_addr_t    vdp_adr,
    output vdp_glue_pkg::host_data_t    vdp_dbo,
    input  vdp_glue_pkg::host_data_t    vdp_dbi,

    // video from the vdp core
    input  vdp_glue_pkg::colour6_t      vdp_r,
    input  vdp_glue_pkg::colour6_t      vdp_g,
    input  vdp_glue_pkg::colour6_t      vdp_b,
    input  logic                        scanlin_n,
    input  logic                        pal_mode,
    input  logic                        vdp_hdmi_reset,
    input  vdp_glue_pkg::vdp_coord_t    vdp_cx,
    input  vdp_glue_pkg::vdp_coord_t    vdp_cy,

    // toward the video encoder
    output vdp_glue_pkg::colour8_t      rgb_r,
    output vdp_glue_pkg::colour8_t      rgb_g,
    output vdp_glue_pkg::colour8_t      rgb_b,
    output vdp_glue_pkg::raster_coord_t cx,
    output vdp_glue_pkg::raster_coord_t cy,
    output logic                        video_reset
);

    host_req_if host_req ();

    // ------------------------------------------------------------------
    // host side
    // ------------------------------------------------------------------

    host_port_capture host_port_capture_inst (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .mode      (mode),
        .cdo       (cdo),
        .csr_n     (csr_n),
        .csw_n     (csw_n),
        .req_out   (host_req.source)
    );

    assign vdp_req = host_req.req;
    assign vdp_wrt = host_req.wrt;
    assign vdp_adr = host_req.adr;
    assign vdp_dbo = host_req.dbo;

    // read data straight from the core
    assign cdi     = vdp_dbi;

    // ------------------------------------------------------------------
    // video side
    // ------------------------------------------------------------------

    raster_aligner raster_aligner_inst (
        .clk_w          (clk_w),
        .reset_n_w      (reset_n_w),
        .pal_mode       (pal_mode),
        .vdp_hdmi_reset (vdp_hdmi_reset),
        .vdp_cx         (vdp_cx),
        .vdp_cy         (vdp_cy),
        .cx             (cx),
        .cy             (cy),
        .video_reset    (video_reset)
    );

    // odd line straight off the raster counter
    scanline_expander scanline_expander_inst (
        .clk_w     (clk_w),
        .reset_n_w (reset_n_w),
        .scanlin_n (scanlin_n),
        .line_odd  (cy[0]),
        .vdp_r     (vdp_r),
        .vdp_g     (vdp_g),
        .vdp_b     (vdp_b),
        .rgb_r     (rgb_r),
        .rgb_g     (rgb_g),
        .rgb_b     (rgb_b)
    );

endmodule

/* rtl/scanline_expander.sv */
// one-cycle colour path; line_odd must come from the raster line of the same input cycle
`timescale 1ns/1ns

module scanline_expander (
    input  logic                   clk_w,
    input  logic                   reset_n_w,
    input  logic                   scanlin_n,
    input  logic                   line_odd,
    input  vdp_glue_pkg::colour6_t vdp_r,
    input  vdp_glue_pkg::colour6_t vdp_g,
    input  vdp_glue_pkg::colour6_t vdp_b,
    output vdp_glue_pkg::colour8_t rgb_r,
    output vdp_glue_pkg::colour8_t rgb_g,
    output vdp_glue_pkg::colour8_t rgb_b
);

    logic dim;

    // scanline effect on, odd raster line
    assign dim = !scanlin_n && line_odd;

    // ------------------------------------------------------------------
    // expansion
    // ------------------------------------------------------------------

    // normal: colour in the top six bits
    // dimmed: shifted down one, roughly half brightness
    function automatic vdp_glue_pkg::colour8_t expand(
        input vdp_glue_pkg::colour6_t c,
        input logic                   half
    );
        vdp_glue_pkg::colour8_t result;
        if (half) begin
            result = {1'b0, c, 1'b0};
        end else begin
            result = {c, 2'b00};
        end
        return result;
    endfunction

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            rgb_r <= '0;
            rgb_g <= '0;
            rgb_b <= '0;
        end else begin
            rgb_r <= expand(vdp_r, dim);
            rgb_g <= expand(vdp_g, dim);
            rgb_b <= expand(vdp_b, dim);
        end
    end

endmodule

/* rtl/raster_aligner.sv */
// free-running 480p/576p raster; pal_mode should only change while the vdp is resyncing
`timescale 1ns/1ns

module raster_aligner (
    input  logic                        clk_w,
    input  logic                        reset_n_w,
    input  logic                        pal_mode,
    input  logic                        vdp_hdmi_reset,
    input  vdp_glue_pkg::vdp_coord_t    vdp_cx,
    input  vdp_glue_pkg::vdp_coord_t    vdp_cy,
    output vdp_glue_pkg::raster_coord_t cx,
    output vdp_glue_pkg::raster_coord_t cy,
    output logic                        video_reset
);

    vdp_glue_pkg::raster_coord_t h_total;
    vdp_glue_pkg::raster_coord_t h_last;
    vdp_glue_pkg::raster_coord_t v_last;
    vdp_glue_pkg::raster_coord_t start_x;
    vdp_glue_pkg::raster_coord_t start_y;
    logic                        origin_seen;
    logic                        origin_misaligned;

    // ------------------------------------------------------------------
    // timing selection
    // ------------------------------------------------------------------

    assign h_total = pal_mode ? vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::PAL_H_TOTAL)
                              : vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::NTSC_H_TOTAL);

    // last column before the line wraps
    assign h_last  = h_total - 10'd1;

    // last line before the frame wraps
    assign v_last  = pal_mode ? vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::PAL_V_TOTAL - 1)
                              : vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::NTSC_V_TOTAL - 1);

    assign start_x = vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::START_X);

    // line the vdp origin should land on
    assign start_y = pal_mode ? vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::PAL_START_Y)
                              : vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::NTSC_START_Y);

    // ------------------------------------------------------------------
    // origin compare
    // ------------------------------------------------------------------

    // vdp at its own (0,0)
    assign origin_seen       = (vdp_cx == '0) && (vdp_cy == '0);

    // raster not where it should be at that moment
    assign origin_misaligned = origin_seen && ((cx != start_x) || (cy != start_y));

    // ------------------------------------------------------------------
    // raster counter
    // ------------------------------------------------------------------

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            cx          <= vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::START_X);
            cy          <= vdp_glue_pkg::raster_coord_t'(vdp_glue_pkg::NTSC_START_Y);
            video_reset <= 1'b0;
        end else begin
            // core reset request or a late/early origin both resync
            video_reset <= vdp_hdmi_reset || origin_misaligned;

            if (video_reset) begin
                // park on the expected origin
                cx <= start_x;
                cy <= start_y;
            end else if (cx >= h_last) begin
                cx <= '0;
                // >= keeps a pal to ntsc switch from running past the end
                if (cy >= v_last) begin
                    cy <= '0;
                end else begin
                    cy <= cy + 10'd1;
                end
            end else begin
                cx <= cx + 10'd1;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // column stays inside the line for the mode it was counted in
    a_cx_in_line : assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        $stable(pal_mode) |-> (cx < h_total)
    );

endmodule

/* rtl/host_port_capture.sv */
// csr_n/csw_n assumed settled at clk_w edges (no synchronizer); both low is no request
`timescale 1ns/1ns

module host_port_capture (
    input  logic                     clk_w,
    input  logic                     reset_n_w,
    input  vdp_glue_pkg::host_addr_t mode,
    input  vdp_glue_pkg::host_data_t cdo,
    input  logic                     csr_n,
    input  logic                     csw_n,
    host_req_if.source               req_out
);

    // sample takes one look at the pins, wait holds until they move
    typedef enum logic {
        ST_SAMPLE,
        ST_WAIT
    } cap_state_t;

    cap_state_t               state;
    logic [1:0]               cs_latch;
    logic [1:0]               cs_pins;
    logic                     strobe_req;
    logic                     req_r;
    logic                     wrt_r;
    vdp_glue_pkg::host_addr_t adr_r;
    vdp_glue_pkg::host_data_t dbo_r;

    assign cs_pins    = {csr_n, csw_n};
    // exactly one strobe active
    assign strobe_req = csr_n ^ csw_n;

    // ------------------------------------------------------------------
    // strobe fsm
    // ------------------------------------------------------------------

    always_ff @(posedge clk_w or negedge reset_n_w) begin
        if (!reset_n_w) begin
            state    <= ST_SAMPLE;
            cs_latch <= 2'b11;
            req_r    <= 1'b0;
            wrt_r    <= 1'b0;
        end else begin
            case (state)
                ST_SAMPLE: begin
                    req_r    <= strobe_req;
                    // write only when csw_n alone is low
                    wrt_r    <= strobe_req && !csw_n;
                    // remember the level so a held strobe fires once
                    cs_latch <= cs_pins;
                    state    <= ST_WAIT;
                end
                default: begin
                    req_r <= 1'b0;
                    wrt_r <= 1'b0;
                    // any edge on either pin rearms the sampler
                    if (cs_pins != cs_latch) begin
                        state <= ST_SAMPLE;
                    end
                end
            endcase
        end
    end

    // address and data follow the sample cycle
    always_ff @(posedge clk_w) begin
        if (state == ST_SAMPLE) begin
            adr_r <= mode;
            dbo_r <= cdo;
        end
    end

    assign req_out.req = req_r;
    assign req_out.wrt = wrt_r;
    assign req_out.adr = adr_r;
    assign req_out.dbo = dbo_r;

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    // the vdp sees a pulse, never a level
    a_req_single_cycle : assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        req_r |=> !req_r
    );

    // the core treats wrt without req as garbage
    a_wrt_needs_req : assert property (
        @(posedge clk_w) disable iff (!reset_n_w)
        wrt_r |-> req_r
    );

endmodule

/* rtl/host_req_if.sv */
// one-cycle host request toward the vdp core; no acknowledge, the core takes every pulse
`timescale 1ns/1ns

interface host_req_if;

    // single-cycle request strobe
    logic                     req;
    // write flag, only high together with req
    logic                     wrt;
    // port select, valid while req is high
    vdp_glue_pkg::host_addr_t adr;
    // write data, valid while req is high
    vdp_glue_pkg::host_data_t dbo;

    // capture side
    modport source (
        output req,
        output wrt,
        output adr,
        output dbo
    );

    // vdp side
    modport sink (
        input  req,
        input  wrt,
        input  adr,
        input  dbo
    );

endinterface

/* rtl/vdp_glue_pkg.sv */
// shared widths, types and 480p/576p raster timings; totals assume one pixel per clk_w
package vdp_glue_pkg;

    // ------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------

    localparam int COLOUR6_W      = 6;
    localparam int COLOUR8_W      = 8;
    localparam int VDP_COORD_W    = 11;
    localparam int RASTER_COORD_W = 10;
    localparam int HOST_ADDR_W    = 2;
    localparam int HOST_DATA_W    = 8;

    // vdp colour channel as it leaves the core
    typedef logic [COLOUR6_W-1:0]      colour6_t;
    // expanded channel toward the video encoder
    typedef logic [COLOUR8_W-1:0]      colour8_t;
    // vdp internal position counters
    typedef logic [VDP_COORD_W-1:0]    vdp_coord_t;
    // glue raster position, wide enough for 864 and 625
    typedef logic [RASTER_COORD_W-1:0] raster_coord_t;
    // vdp port select, taken from the mode pins
    typedef logic [HOST_ADDR_W-1:0]    host_addr_t;
    // host data byte
    typedef logic [HOST_DATA_W-1:0]    host_data_t;

    // ------------------------------------------------------------------
    // raster timings
    // ------------------------------------------------------------------

    // 480p, ntsc derived
    localparam int NTSC_H_TOTAL = 858;
    localparam int NTSC_V_TOTAL = 525;

    // 576p, pal
    localparam int PAL_H_TOTAL  = 864;
    localparam int PAL_V_TOTAL  = 625;

    // raster line expected under the vdp origin
    // 45 lines before the ntsc frame end
    localparam int NTSC_START_Y = 480;
    // 60 lines before the pal frame end
    localparam int PAL_START_Y  = 565;

    // raster column under the vdp origin, same for both standards
    localparam int START_X      = 0;

endpackage
